// ==== include/game_params.svh ====
// game geometry and timing constants
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// ----------------------------------------------------------------------
// screen and sprite size, in pixels
// ----------------------------------------------------------------------
`define SCREEN_W    1024
`define SCREEN_H    768
`define SPRITE_W    48
`define SPRITE_H    64

// upper-left corner at power-up, sprite starts in the air
`define SPAWN_X     500
`define SPAWN_Y     503
`define JUMP_HEIGHT 200

// ----------------------------------------------------------------------
// platforms as left x, top row, length in columns
// ----------------------------------------------------------------------
`define PLAT_COUNT  2
`define PLAT0_X     100
`define PLAT0_Y     600
`define PLAT0_LEN   200
`define PLAT1_X     700
`define PLAT1_Y     480
`define PLAT1_LEN   220

// step periods, counted in prescaler ticks
`define WALK_PERIOD 4
`define RISE_START  2
`define RISE_INC    1
`define RISE_LIMIT  8
`define FALL_START  8
`define FALL_DEC    1
`define FALL_LIMIT  2

// PS/2 set 2 codes
`define SCAN_LEFT   8'h6B
`define SCAN_RIGHT  8'h74
`define SCAN_SPACE  8'h29
`define SCAN_BREAK  8'hF0
`define SCAN_EXT    8'hE0

`endif

// ==== source/game_pkg.sv ====
// player movement types
package game_pkg;

    // ------------------------------------------------------------------
    // coordinates and keyboard bytes
    // ------------------------------------------------------------------

    // screen position, wide enough for 1023 columns
    typedef logic [9:0] coord_t;

    // one byte from the keyboard stream
    typedef logic [7:0] scan_byte_t;

    // ------------------------------------------------------------------
    // movement FSM
    // ------------------------------------------------------------------

    // idle    resting on something, no walk key
    // moving  resting on something, walking
    // jumping rising from the jump start
    // falling dropping until ground
    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_moving  = 2'b01,
        st_jumping = 2'b11,
        st_falling = 2'b10
    } move_state_t;

endpackage

// ==== source/key_decoder.sv ====
// scan-code key decoder
`include "game_params.svh"

module key_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::scan_byte_t scan_byte,
    input  logic                 scan_valid,
    output logic                 left,
    output logic                 right,
    output logic                 jump
);

    import game_pkg::*;

    // ------------------------------------------------------------------
    // codes of interest
    // ------------------------------------------------------------------
    localparam scan_byte_t CODE_LEFT  = `SCAN_LEFT;
    localparam scan_byte_t CODE_RIGHT = `SCAN_RIGHT;
    localparam scan_byte_t CODE_SPACE = `SCAN_SPACE;
    localparam scan_byte_t CODE_BREAK = `SCAN_BREAK;
    localparam scan_byte_t CODE_EXT   = `SCAN_EXT;

    // prefixes seen since the last complete code
    logic brk_pend;
    logic ext_pend;

    // level a completed code writes, low after F0
    logic key_level;

    logic is_prefix;

    assign key_level = !brk_pend;
    assign is_prefix = (scan_byte == CODE_BREAK) || (scan_byte == CODE_EXT);

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            brk_pend <= 1'b0;
            ext_pend <= 1'b0;
            left     <= 1'b0;
            right    <= 1'b0;
            jump     <= 1'b0;
        end else if (scan_valid) begin
            if (scan_byte == CODE_BREAK) begin
                brk_pend <= 1'b1;
            end else if (scan_byte == CODE_EXT) begin
                ext_pend <= 1'b1;
            end else begin
                // arrows live in the extended set, space does not
                if (ext_pend) begin
                    case (scan_byte)
                        CODE_LEFT:  left  <= key_level;
                        CODE_RIGHT: right <= key_level;
                        default: ;
                    endcase
                end else if (scan_byte == CODE_SPACE) begin
                    jump <= key_level;
                end
                // any complete code ends the sequence
                brk_pend <= 1'b0;
                ext_pend <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // a stale prefix would corrupt the next key
    prefix_cleared: assert property (
        @(posedge clk) disable iff (rst)
        (scan_valid && !is_prefix) |=> (!brk_pend && !ext_pend)
    );

endmodule

// ==== source/platform_collision.sv ====
// sprite box collision test
`include "game_params.svh"

module platform_collision (
    input  game_pkg::coord_t cand_x,
    input  game_pkg::coord_t cand_y,
    output logic             on_ground,
    output logic             head_hit
);

    import game_pkg::*;

    localparam int PLAT_N = `PLAT_COUNT;

    // ------------------------------------------------------------------
    // platform table
    // ------------------------------------------------------------------
    localparam coord_t PLAT_X [PLAT_N] = '{coord_t'(`PLAT0_X), coord_t'(`PLAT1_X)};
    localparam coord_t PLAT_Y [PLAT_N] = '{coord_t'(`PLAT0_Y), coord_t'(`PLAT1_Y)};

    // last column of each platform, one bit wider
    localparam logic [10:0] PLAT_R [PLAT_N] = '{
        11'(`PLAT0_X + `PLAT0_LEN - 1),
        11'(`PLAT1_X + `PLAT1_LEN - 1)
    };

    // row just under each platform
    localparam coord_t PLAT_UNDER [PLAT_N] = '{
        coord_t'(`PLAT0_Y + 1),
        coord_t'(`PLAT1_Y + 1)
    };

    // sprite right column and first row below it
    logic [10:0] spr_right;
    logic [10:0] spr_bottom;
    logic        overlap;

    assign spr_right  = {1'b0, cand_x} + 11'(`SPRITE_W - 1);
    assign spr_bottom = {1'b0, cand_y} + 11'(`SPRITE_H);

    always_comb begin
        on_ground = (spr_bottom == 11'(`SCREEN_H));
        head_hit  = 1'b0;
        overlap   = 1'b0;
        for (int i = 0; i < PLAT_N; i++) begin
            // shared column between the two spans
            overlap = ({1'b0, cand_x} <= PLAT_R[i]) && ({1'b0, PLAT_X[i]} <= spr_right);
            if (overlap && (spr_bottom == {1'b0, PLAT_Y[i]})) begin
                on_ground = 1'b1;
            end
            if (overlap && (cand_y == PLAT_UNDER[i])) begin
                head_hit = 1'b1;
            end
        end
    end

endmodule

// ==== source/move_ctrl.sv ====
// player movement controller
`include "game_params.svh"

module move_ctrl #(
    parameter int PRESCALE = 4000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             left,
    input  logic             right,
    input  logic             jump,
    input  logic             on_ground,
    input  logic             head_hit,
    output game_pkg::coord_t cand_x,
    output game_pkg::coord_t cand_y,
    output game_pkg::coord_t x,
    output game_pkg::coord_t y
);

    import game_pkg::*;

    // ------------------------------------------------------------------
    // constants
    // ------------------------------------------------------------------
    localparam int PRE_W  = $clog2(PRESCALE + 1);
    localparam int STEP_W = 4;

    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE - 1);

    localparam coord_t X_MAX   = coord_t'(`SCREEN_W - `SPRITE_W);
    localparam coord_t Y_MAX   = coord_t'(`SCREEN_H - `SPRITE_H);
    localparam coord_t SPAWN_X = coord_t'(`SPAWN_X);
    localparam coord_t SPAWN_Y = coord_t'(`SPAWN_Y);
    localparam coord_t JUMP_H  = coord_t'(`JUMP_HEIGHT);

    localparam logic [STEP_W-1:0] WALK_LAST  = STEP_W'(`WALK_PERIOD - 1);
    localparam logic [STEP_W-1:0] RISE_START = STEP_W'(`RISE_START);
    localparam logic [STEP_W-1:0] RISE_INC   = STEP_W'(`RISE_INC);
    localparam logic [STEP_W-1:0] RISE_LIMIT = STEP_W'(`RISE_LIMIT);
    localparam logic [STEP_W-1:0] FALL_START = STEP_W'(`FALL_START);
    localparam logic [STEP_W-1:0] FALL_DEC   = STEP_W'(`FALL_DEC);
    localparam logic [STEP_W-1:0] FALL_LIMIT = STEP_W'(`FALL_LIMIT);

    move_state_t state;
    move_state_t state_nxt;

    // low until the spawn point has been loaded
    logic spawned;

    logic [PRE_W-1:0]  pre_cnt;
    logic              tick;

    logic [STEP_W-1:0] x_cnt;
    logic [STEP_W-1:0] x_cnt_nxt;
    logic [STEP_W-1:0] y_cnt;
    logic [STEP_W-1:0] y_cnt_nxt;
    logic [STEP_W-1:0] y_period;
    logic [STEP_W-1:0] y_period_nxt;

    coord_t y_start;
    coord_t y_start_nxt;
    coord_t rise_dist;

    logic walk_on;
    logic x_step;
    logic y_step;

    // ------------------------------------------------------------------
    // step timing
    // ------------------------------------------------------------------
    assign tick    = (pre_cnt == PRE_LAST);
    assign walk_on = spawned && (left ^ right) && (state != st_idle);
    assign x_step  = walk_on && tick && (x_cnt >= WALK_LAST);
    assign y_step  = tick && (y_cnt >= y_period - STEP_W'(1));

    always_comb begin
        if (!walk_on || x_step) begin
            x_cnt_nxt = '0;
        end else if (tick) begin
            x_cnt_nxt = x_cnt + STEP_W'(1);
        end else begin
            x_cnt_nxt = x_cnt;
        end
    end

    // ------------------------------------------------------------------
    // candidate position, clamped to the screen
    // ------------------------------------------------------------------
    always_comb begin
        cand_x = x;
        cand_y = y;
        if (!spawned) begin
            cand_x = SPAWN_X;
            cand_y = SPAWN_Y;
        end else begin
            if (x_step) begin
                if (right && (x < X_MAX)) begin
                    cand_x = x + coord_t'(1);
                end else if (left && (x != '0)) begin
                    cand_x = x - coord_t'(1);
                end
            end
            if (y_step) begin
                if ((state == st_jumping) && (y != '0)) begin
                    cand_y = y - coord_t'(1);
                end else if ((state == st_falling) && (y < Y_MAX)) begin
                    cand_y = y + coord_t'(1);
                end
            end
        end
    end

    assign rise_dist = y_start - cand_y;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt    = state;
        y_start_nxt  = y_start;
        y_cnt_nxt    = '0;
        y_period_nxt = y_period;
        case (state)
            st_idle, st_moving: begin
                if (!spawned) begin
                    state_nxt = st_idle;
                end else if (!on_ground) begin
                    state_nxt    = st_falling;
                    y_period_nxt = FALL_START;
                end else if (jump) begin
                    state_nxt    = st_jumping;
                    y_start_nxt  = y;
                    y_period_nxt = RISE_START;
                end else if (left ^ right) begin
                    state_nxt = st_moving;
                end else begin
                    state_nxt = st_idle;
                end
            end
            st_jumping: begin
                if (y_step) begin
                    // slow down on the way up
                    if (y_period < RISE_LIMIT) begin
                        y_period_nxt = y_period + RISE_INC;
                    end
                end else if (tick) begin
                    y_cnt_nxt = y_cnt + STEP_W'(1);
                end else begin
                    y_cnt_nxt = y_cnt;
                end
                if (head_hit || (cand_y == '0) || (rise_dist >= JUMP_H)) begin
                    state_nxt    = st_falling;
                    y_cnt_nxt    = '0;
                    y_period_nxt = FALL_START;
                end
            end
            st_falling: begin
                if (y_step) begin
                    // speed up on the way down
                    if (y_period > FALL_LIMIT) begin
                        y_period_nxt = y_period - FALL_DEC;
                    end
                end else if (tick) begin
                    y_cnt_nxt = y_cnt + STEP_W'(1);
                end else begin
                    y_cnt_nxt = y_cnt;
                end
                if (on_ground) begin
                    state_nxt = st_idle;
                    y_cnt_nxt = '0;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            spawned  <= 1'b0;
            pre_cnt  <= '0;
            x_cnt    <= '0;
            y_cnt    <= '0;
            y_period <= FALL_START;
            x        <= '0;
            y        <= '0;
        end else begin
            state    <= state_nxt;
            spawned  <= 1'b1;
            pre_cnt  <= tick ? '0 : pre_cnt + PRE_W'(1);
            x_cnt    <= x_cnt_nxt;
            y_cnt    <= y_cnt_nxt;
            y_period <= y_period_nxt;
            x        <= cand_x;
            y        <= cand_y;
        end
    end

    // height the current jump started from
    always_ff @(posedge clk) begin
        y_start <= y_start_nxt;
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    x_in_screen: assert property (@(posedge clk) disable iff (rst) x <= X_MAX);

    y_in_screen: assert property (@(posedge clk) disable iff (rst) y <= Y_MAX);

    state_legal: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(state) && (state inside {st_idle, st_moving, st_jumping, st_falling})
    );

endmodule

// ==== source/player_top.sv ====
// player movement top level
module player_top #(
    parameter int PRESCALE = 4000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::scan_byte_t scan_byte,
    input  logic                 scan_valid,
    output game_pkg::coord_t     x,
    output game_pkg::coord_t     y
);

    import game_pkg::*;

    // held keys
    logic left;
    logic right;
    logic jump;

    // position under test and its contacts
    coord_t cand_x;
    coord_t cand_y;
    logic   on_ground;
    logic   head_hit;

    // ------------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------------
    key_decoder u_keys (
        .clk        (clk),
        .rst        (rst),
        .scan_byte  (scan_byte),
        .scan_valid (scan_valid),
        .left       (left),
        .right      (right),
        .jump       (jump)
    );

    move_ctrl #(
        .PRESCALE (PRESCALE)
    ) u_move (
        .clk       (clk),
        .rst       (rst),
        .left      (left),
        .right     (right),
        .jump      (jump),
        .on_ground (on_ground),
        .head_hit  (head_hit),
        .cand_x    (cand_x),
        .cand_y    (cand_y),
        .x         (x),
        .y         (y)
    );

    platform_collision u_collide (
        .cand_x    (cand_x),
        .cand_y    (cand_y),
        .on_ground (on_ground),
        .head_hit  (head_hit)
    );

endmodule

// ==== sim/player_tb.sv ====
// player movement testbench
`include "game_params.svh"

module player_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;

    localparam int TIMEOUT = 10000;
    localparam int FLOOR_Y = `SCREEN_H - `SPRITE_H;
    localparam int X_MAX   = `SCREEN_W - `SPRITE_W;

    // check windows selected by the stimulus
    localparam int PH_NONE  = 0;
    localparam int PH_DROP  = 1;
    localparam int PH_RIGHT = 2;
    localparam int PH_LEFT  = 3;
    localparam int PH_STILL = 4;
    localparam int PH_JUMP  = 5;

    logic       clk;
    logic       rst;
    scan_byte_t scan_byte;
    logic       scan_valid;
    coord_t     x;
    coord_t     y;

    int   phase;
    int   errors;
    int   seed;
    int   jump_base;
    int   y_last;
    logic descending;

    player_top #(
        .PRESCALE (1)
    ) i_player_top (
        .clk        (clk),
        .rst        (rst),
        .scan_byte  (scan_byte),
        .scan_valid (scan_valid),
        .x          (x),
        .y          (y)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2;
            clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic send_byte(input scan_byte_t b);
        @(posedge clk);
        #1;
        scan_byte  = b;
        scan_valid = 1'b1;
    endtask

    // make or break of one key with its prefixes
    task automatic send_key(input logic ext, input logic brk, input scan_byte_t code);
        if (ext) begin
            send_byte(`SCAN_EXT);
        end
        if (brk) begin
            send_byte(`SCAN_BREAK);
        end
        send_byte(code);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        scan_valid = 1'b0;
        scan_byte  = '0;
    endtask

    task automatic pause(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic random_pause();
        pause(16 + ($random(seed) & 15));
    endtask

    // on_y picks the coordinate to watch
    task automatic wait_for_pos(input logic on_y, input int target);
        int cycles;
        cycles = 0;
        while ((int'(on_y ? y : x) != target) && (cycles < TIMEOUT)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (int'(on_y ? y : x) != target) begin
            $display("TEST FAIL");
            $fatal(1, "position never reached %0d within %0d cycles", target, TIMEOUT);
        end
    endtask

    // first resting row below the peak or the floor when nothing overlaps
    function automatic int landing_row(input int col, input int peak);
        int plat_x [`PLAT_COUNT] = '{`PLAT0_X, `PLAT1_X};
        int plat_y [`PLAT_COUNT] = '{`PLAT0_Y, `PLAT1_Y};
        int plat_n [`PLAT_COUNT] = '{`PLAT0_LEN, `PLAT1_LEN};
        int row;
        row = FLOOR_Y;
        for (int i = 0; i < `PLAT_COUNT; i++) begin
            if ((col <= plat_x[i] + plat_n[i] - 1) && (plat_x[i] <= col + `SPRITE_W - 1)
                    && (plat_y[i] - `SPRITE_H >= peak) && (plat_y[i] - `SPRITE_H < row)) begin
                row = plat_y[i] - `SPRITE_H;
            end
        end
        return row;
    endfunction

    // marks the turn from rising to falling
    always @(negedge clk) begin
        if (phase != PH_JUMP) begin
            descending = 1'b0;
        end else if (int'(y) > y_last) begin
            descending = 1'b1;
        end
        y_last = int'(y);
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    spawn_point: assert property (@(posedge clk)
        $fell(rst) |=> (int'(x) == `SPAWN_X) && (int'(y) == `SPAWN_Y)
    ) else report_mismatch("position after reset is not the spawn point");

    drop_down: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_DROP) |-> (y >= $past(y)) && (int'(y) <= FLOOR_Y)
    ) else report_mismatch("y moved up or below the floor while dropping");

    walk_right: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_RIGHT) |-> (y == $past(y)) && (int'(x) <= X_MAX)
            && ((x == $past(x)) || (int'(x) == int'($past(x)) + 1))
    ) else report_mismatch("bad x or y step while walking right");

    walk_left: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_LEFT) |-> (y == $past(y))
            && ((x == $past(x)) || (int'(x) == int'($past(x)) - 1))
    ) else report_mismatch("bad x or y step while walking left");

    stand_still: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_STILL) |-> (x == $past(x))
    ) else report_mismatch("x changed with no single walk key held");

    jump_step: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_JUMP) |-> (x == $past(x)) && (int'(y) >= jump_base - `JUMP_HEIGHT)
            && ((y == $past(y)) || (int'(y) == int'($past(y)) - 1)
                || (int'(y) == int'($past(y)) + 1))
    ) else report_mismatch("jump step too large or above the jump height");

    jump_shape: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_JUMP) && descending |-> (y >= $past(y))
    ) else report_mismatch("sprite rose again after starting to fall");

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int land_y;
        seed       = 90;
        errors     = 0;
        phase      = PH_DROP;
        jump_base  = 0;
        y_last     = 0;
        descending = 1'b0;
        rst        = 1'b1;
        scan_byte  = '0;
        scan_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // spawn in the air and drop to the floor
        wait_for_pos(1'b1, FLOOR_Y);
        random_pause();

        // right arrow without E0 is not an arrow
        phase = PH_STILL;
        send_key(1'b0, 1'b0, `SCAN_RIGHT);
        bus_idle();
        random_pause();
        send_key(1'b0, 1'b1, `SCAN_RIGHT);
        bus_idle();
        random_pause();

        // both arrows held and then released
        phase = PH_NONE;
        send_key(1'b1, 1'b0, `SCAN_LEFT);
        send_key(1'b1, 1'b0, `SCAN_RIGHT);
        bus_idle();
        pause(2);
        phase = PH_STILL;
        random_pause();
        send_key(1'b1, 1'b1, `SCAN_LEFT);
        send_key(1'b1, 1'b1, `SCAN_RIGHT);
        bus_idle();
        random_pause();

        // sprite still stands on the floor below its spawn column
        phase     = PH_JUMP;
        jump_base = FLOOR_Y;
        land_y    = landing_row(`SPAWN_X, jump_base - `JUMP_HEIGHT);
        send_key(1'b0, 1'b0, `SCAN_SPACE);
        send_key(1'b0, 1'b1, `SCAN_SPACE);
        bus_idle();
        wait_for_pos(1'b1, jump_base - `JUMP_HEIGHT);
        wait_for_pos(1'b1, land_y);
        random_pause();
        landed: assert (int'(y) == land_y)
            else report_mismatch("sprite did not stay at its landing row");

        // walk right into the screen edge
        phase = PH_RIGHT;
        send_key(1'b1, 1'b0, `SCAN_RIGHT);
        bus_idle();
        wait_for_pos(1'b0, X_MAX);
        random_pause();
        send_key(1'b1, 1'b1, `SCAN_RIGHT);
        bus_idle();
        pause(8);
        clamp_right: assert (int'(x) == X_MAX)
            else report_mismatch("x not held at the right edge");

        // and back to the left edge
        phase = PH_LEFT;
        send_key(1'b1, 1'b0, `SCAN_LEFT);
        bus_idle();
        wait_for_pos(1'b0, 0);
        random_pause();
        send_key(1'b1, 1'b1, `SCAN_LEFT);
        bus_idle();
        pause(8);
        clamp_left: assert (x == '0)
            else report_mismatch("x not held at the left edge");

        phase = PH_NONE;
        pause(4);
        if (errors == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

// ==== all.f ====
+incdir+include
source/game_pkg.sv
source/key_decoder.sv
source/platform_collision.sv
source/move_ctrl.sv
source/player_top.sv
sim/player_tb.sv

// ==== Makefile ====
# Verilator build and run of the player movement testbench

TOP = player_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
